/* src/sched_pkg.sv */
package sched_pkg;

    localparam int DATA_W    = 32;
    localparam int NUM_PREGS = 32;
    localparam int NUM_WR    = 2;

    typedef logic [$clog2(NUM_PREGS)-1:0] t_preg_id;
    typedef logic [5:0]                   t_rob_id;
    typedef logic [DATA_W-1:0]            t_data;

    typedef enum logic [1:0] {
        OP_ZERO,
        OP_IMM,
        OP_REG
    } t_optype;

    typedef enum logic [2:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_LOAD
    } t_uop;

    typedef enum logic {
        FU_EXE,
        FU_MEM
    } t_fu;

    typedef struct packed {
        t_uop     uop;
        t_optype  src1_optype;
        t_optype  src2_optype;
        t_preg_id psrc1;
        t_preg_id psrc2;
        logic     src1_ready;
        logic     src2_ready;
        t_preg_id pdst;
        t_rob_id  robid;
        t_data    imm;
    } t_disp_pkt;

    // Dispatch fields travel unchanged, operand values filled at issue
    typedef struct packed {
        t_disp_pkt disp;
        t_data     src1_val;
        t_data     src2_val;
    } t_iss_pkt;

    typedef struct packed {
        t_preg_id preg;
        t_data    data;
    } t_wr_pkt;

    function automatic t_fu uop_to_fu(input t_uop uop);
        if (uop == UOP_LOAD) begin
            return FU_MEM;
        end
        return FU_EXE;
    endfunction

    function automatic t_data opsel(input t_optype optype, input t_data imm,
                                    input t_data reg_data);
        case (optype)
            OP_IMM:  return imm;
            OP_REG:  return reg_data;
            default: return '0;
        endcase
    endfunction

endpackage

/* src/rs_entry.sv */
`timescale 1ns/10ps

module rs_entry (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 wr_en  [sched_pkg::NUM_WR],
    input  sched_pkg::t_wr_pkt   wr_pkt [sched_pkg::NUM_WR],
    input  logic                 alloc,
    input  sched_pkg::t_disp_pkt alloc_pkt,
    input  logic                 gnt,
    output logic                 valid,
    output logic                 req,
    output sched_pkg::t_iss_pkt  iss_pkt
);

    import sched_pkg::*;

    t_disp_pkt pkt;
    logic      src1_rdy;
    logic      src2_rdy;
    logic      alloc_rdy1;
    logic      alloc_rdy2;

    // Any write port targeting this register this cycle
    function automatic logic wake_hit(input t_preg_id preg);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < NUM_WR; w++) begin
            if (wr_en[w] && wr_pkt[w].preg == preg) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Immediate and zero sources never wait
    always_comb begin
        alloc_rdy1 = (alloc_pkt.src1_optype != OP_REG) || alloc_pkt.src1_ready
                     || wake_hit(alloc_pkt.psrc1);
        alloc_rdy2 = (alloc_pkt.src2_optype != OP_REG) || alloc_pkt.src2_ready
                     || wake_hit(alloc_pkt.psrc2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= 1'b1;
        end else if (gnt) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            src1_rdy <= 1'b0;
            src2_rdy <= 1'b0;
        end else if (alloc) begin
            src1_rdy <= alloc_rdy1;
            src2_rdy <= alloc_rdy2;
        end else begin
            src1_rdy <= src1_rdy || wake_hit(pkt.psrc1);
            src2_rdy <= src2_rdy || wake_hit(pkt.psrc2);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            pkt <= alloc_pkt;
        end
    end

    assign req = valid && src1_rdy && src2_rdy;

    always_comb begin
        iss_pkt          = '0;
        iss_pkt.disp     = pkt;
        iss_pkt.src1_val = '0;
        iss_pkt.src2_val = '0;
    end

    // Arbiter in rs must only pick a requesting slot
    a_gnt_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n) gnt |-> req
    );

endmodule

/* src/rs.sv */
`timescale 1ns/10ps

module rs #(
    parameter int NUM_RS_ENTS = 8
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 wr_en  [sched_pkg::NUM_WR],
    input  sched_pkg::t_wr_pkt   wr_pkt [sched_pkg::NUM_WR],
    input  logic                 disp_valid,
    input  sched_pkg::t_disp_pkt disp_pkt,
    output logic                 disp_ready,
    output logic                 rd_en   [2],
    output sched_pkg::t_preg_id  rd_addr [2],
    input  sched_pkg::t_data     rd_data [2],
    output logic                 ex_iss,
    output sched_pkg::t_iss_pkt  ex_iss_pkt,
    output logic                 mm_iss,
    output sched_pkg::t_iss_pkt  mm_iss_pkt
);

    import sched_pkg::*;

    logic [NUM_RS_ENTS-1:0] ent_valid;
    logic [NUM_RS_ENTS-1:0] ent_req;
    logic [NUM_RS_ENTS-1:0] alloc_vec;
    logic [NUM_RS_ENTS-1:0] req_sel;
    logic [NUM_RS_ENTS-1:0] gnt_vec;
    t_iss_pkt               ent_pkt [NUM_RS_ENTS];
    logic                   iss_rs1;
    t_iss_pkt               iss_pkt_rs1;
    logic                   iss_q_rs2;
    t_iss_pkt               iss_pkt_q_rs2;
    logic                   iss_rs2;
    t_iss_pkt               iss_pkt_rs2;
    t_fu                    fu_rs2;

    // One-hot of the lowest set bit
    function automatic logic [NUM_RS_ENTS-1:0] find_first(input logic [NUM_RS_ENTS-1:0] vec);
        logic [NUM_RS_ENTS-1:0] sel;
        sel = '0;
        for (int i = NUM_RS_ENTS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                sel    = '0;
                sel[i] = 1'b1;
            end
        end
        return sel;
    endfunction

    // Allocation
    assign disp_ready = ~&ent_valid;
    assign alloc_vec  = (disp_valid && disp_ready) ? find_first(~ent_valid) : '0;

    // Issue arbitration, rs1
    assign req_sel = find_first(ent_req);
    assign iss_rs1 = |ent_req && !flush;
    assign gnt_vec = iss_rs1 ? req_sel : '0;

    always_comb begin
        iss_pkt_rs1 = '0;
        for (int i = 0; i < NUM_RS_ENTS; i++) begin
            if (req_sel[i]) begin
                iss_pkt_rs1 = ent_pkt[i];
            end
        end
    end

    // Register read only for register sources
    always_comb begin
        rd_en[0]   = iss_rs1 && iss_pkt_rs1.disp.src1_optype == OP_REG;
        rd_addr[0] = iss_pkt_rs1.disp.psrc1;
        rd_en[1]   = iss_rs1 && iss_pkt_rs1.disp.src2_optype == OP_REG;
        rd_addr[1] = iss_pkt_rs1.disp.psrc2;
    end

    // Stage rs2
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_q_rs2 <= 1'b0;
        end else begin
            iss_q_rs2 <= iss_rs1;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_rs1) begin
            iss_pkt_q_rs2 <= iss_pkt_rs1;
        end
    end

    assign iss_rs2 = iss_q_rs2 && !flush;

    always_comb begin
        iss_pkt_rs2          = iss_pkt_q_rs2;
        iss_pkt_rs2.src1_val = opsel(iss_pkt_q_rs2.disp.src1_optype, iss_pkt_q_rs2.disp.imm,
                                     rd_data[0]);
        iss_pkt_rs2.src2_val = opsel(iss_pkt_q_rs2.disp.src2_optype, iss_pkt_q_rs2.disp.imm,
                                     rd_data[1]);
    end

    assign fu_rs2     = uop_to_fu(iss_pkt_q_rs2.disp.uop);
    assign ex_iss     = iss_rs2 && fu_rs2 == FU_EXE;
    assign ex_iss_pkt = iss_pkt_rs2;
    assign mm_iss     = iss_rs2 && fu_rs2 == FU_MEM;
    assign mm_iss_pkt = iss_pkt_rs2;

    for (genvar i = 0; i < NUM_RS_ENTS; i++) begin : g_ent
        rs_entry u_ent (
            .clk       (clk),
            .arst_n    (arst_n),
            .flush     (flush),
            .wr_en     (wr_en),
            .wr_pkt    (wr_pkt),
            .alloc     (alloc_vec[i]),
            .alloc_pkt (disp_pkt),
            .gnt       (gnt_vec[i]),
            .valid     (ent_valid[i]),
            .req       (ent_req[i]),
            .iss_pkt   (ent_pkt[i])
        );
    end

    // Accepted op takes exactly one free slot
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        (disp_valid && disp_ready) |-> $onehot(alloc_vec) && (alloc_vec & ent_valid) == '0
    );

    // Single grant per cycle
    a_one_gnt: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(gnt_vec)
    );

endmodule

/* src/prf.sv */
`timescale 1ns/10ps

module prf (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                wr_en   [sched_pkg::NUM_WR],
    input  sched_pkg::t_wr_pkt  wr_pkt  [sched_pkg::NUM_WR],
    input  logic                rd_en   [2],
    input  sched_pkg::t_preg_id rd_addr [2],
    output sched_pkg::t_data    rd_data [2]
);

    import sched_pkg::*;

    t_data regs    [NUM_PREGS];
    t_data rd_next [2];

    // Later port overwrites earlier one on a shared target
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < NUM_PREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_WR; w++) begin
                if (wr_en[w]) begin
                    regs[wr_pkt[w].preg] <= wr_pkt[w].data;
                end
            end
        end
    end

    // Write-first forwarding
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_next[p] = regs[rd_addr[p]];
            for (int w = 0; w < NUM_WR; w++) begin
                if (wr_en[w] && wr_pkt[w].preg == rd_addr[p]) begin
                    rd_next[p] = wr_pkt[w].data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (rd_en[p]) begin
                rd_data[p] <= rd_next[p];
            end
        end
    end

    // ALU writeback and load return must target different registers
    a_wr_conflict: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(wr_en[0] && wr_en[1] && wr_pkt[0].preg == wr_pkt[1].preg)
    );

endmodule

/* src/alu_unit.sv */
`timescale 1ns/10ps

module alu_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ex_iss,
    input  sched_pkg::t_iss_pkt ex_iss_pkt,
    output logic                wb_en,
    output sched_pkg::t_wr_pkt  wb_pkt,
    output sched_pkg::t_rob_id  wb_robid
);

    import sched_pkg::*;

    t_data src_a;
    t_data src_b;
    t_data result;

    always_comb begin
        src_a = ex_iss_pkt.src1_val;
        src_b = ex_iss_pkt.src2_val;
        case (ex_iss_pkt.disp.uop)
            UOP_ADD: result = src_a + src_b;
            UOP_SUB: result = src_a - src_b;
            UOP_AND: result = src_a & src_b;
            UOP_OR:  result = src_a | src_b;
            UOP_XOR: result = src_a ^ src_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex_iss;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_iss) begin
            wb_pkt.preg <= ex_iss_pkt.disp.pdst;
            wb_pkt.data <= result;
            wb_robid    <= ex_iss_pkt.disp.robid;
        end
    end

    // Loads are steered to the memory port
    a_exe_only: assert property (
        @(posedge clk) disable iff (!arst_n)
        ex_iss |-> uop_to_fu(ex_iss_pkt.disp.uop) == FU_EXE
    );

endmodule

/* src/sched_top.sv */
`timescale 1ns/10ps

module sched_top #(
    parameter int NUM_RS_ENTS = 8
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 disp_valid,
    input  sched_pkg::t_disp_pkt disp_pkt,
    output logic                 disp_ready,
    input  logic                 ext_wr_en,
    input  sched_pkg::t_wr_pkt   ext_wr_pkt,
    output logic                 mm_iss,
    output sched_pkg::t_iss_pkt  mm_iss_pkt,
    output logic                 wb_en,
    output sched_pkg::t_wr_pkt   wb_pkt,
    output sched_pkg::t_rob_id   wb_robid
);

    import sched_pkg::*;

    logic     wr_en   [NUM_WR];
    t_wr_pkt  wr_pkt  [NUM_WR];
    logic     rd_en   [2];
    t_preg_id rd_addr [2];
    t_data    rd_data [2];
    logic     ex_iss;
    t_iss_pkt ex_iss_pkt;

    // Port 0 ALU, port 1 load return
    assign wr_en[0]  = wb_en;
    assign wr_pkt[0] = wb_pkt;
    assign wr_en[1]  = ext_wr_en;
    assign wr_pkt[1] = ext_wr_pkt;

    rs #(
        .NUM_RS_ENTS (NUM_RS_ENTS)
    ) u_rs (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .wr_en      (wr_en),
        .wr_pkt     (wr_pkt),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt),
        .disp_ready (disp_ready),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .ex_iss     (ex_iss),
        .ex_iss_pkt (ex_iss_pkt),
        .mm_iss     (mm_iss),
        .mm_iss_pkt (mm_iss_pkt)
    );

    prf u_prf (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .wr_pkt  (wr_pkt),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    alu_unit u_alu (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_iss     (ex_iss),
        .ex_iss_pkt (ex_iss_pkt),
        .wb_en      (wb_en),
        .wb_pkt     (wb_pkt),
        .wb_robid   (wb_robid)
    );

endmodule

/* bench/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Release away from the active edge
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

/* bench/sched_tb_checks.svh */
`ifndef SCHED_TB_CHECKS_SVH
`define SCHED_TB_CHECKS_SVH

task automatic compare_wr(input string name, input t_wr_pkt act, input t_wr_pkt exp);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("FAIL %0t %s got preg %0d data %h, expected preg %0d data %h",
                 $time, name, act.preg, act.data, exp.preg, exp.data);
    end
endtask

task automatic compare_iss(input string name, input t_iss_pkt act, input t_iss_pkt exp);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("FAIL %0t %s got %h, expected %h", $time, name, act, exp);
    end
endtask

task automatic compare_rob(input string name, input t_rob_id act, input t_rob_id exp);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("FAIL %0t %s got %0d, expected %0d", $time, name, act, exp);
    end
endtask

task automatic compare_bit(input string name, input logic act, input logic exp);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("FAIL %0t %s got %b, expected %b", $time, name, act, exp);
    end
endtask

// All loops below return 1 ns after a rising edge
task automatic wait_ready();
    int cyc;
    cyc = 0;
    while (disp_ready !== 1'b1 && cyc < TIMEOUT) begin
        @(posedge clk);
        #1;
        cyc++;
    end
    if (disp_ready !== 1'b1) begin
        err_count++;
        $display("ERROR %0t: disp_ready stayed low for %0d cycles", $time, TIMEOUT);
    end
endtask

task automatic drain_writebacks();
    int cyc;
    cyc = 0;
    while (pending != 0 && cyc < TIMEOUT) begin
        @(posedge clk);
        #1;
        cyc++;
    end
    if (pending != 0) begin
        err_count++;
        $display("ERROR %0t: %0d expected writebacks never arrived", $time, pending);
    end
endtask

task automatic wait_mm(input int target);
    int cyc;
    cyc = 0;
    while (mm_count < target && cyc < TIMEOUT) begin
        @(posedge clk);
        #1;
        cyc++;
    end
    if (mm_count < target) begin
        err_count++;
        $display("ERROR %0t: memory issue never appeared", $time);
    end
endtask

task automatic wait_reset();
    int cyc;
    cyc = 0;
    while (arst_n !== 1'b1 && cyc < TIMEOUT) begin
        @(posedge clk);
        #1;
        cyc++;
    end
    if (arst_n !== 1'b1) begin
        err_count++;
        $display("ERROR %0t: reset was never released", $time);
    end
endtask

`endif

/* bench/sched_tb.sv */
`timescale 1ns/10ps

module sched_tb;

    import sched_pkg::*;

    localparam int NUM_RS_ENTS = 8;
    localparam int TIMEOUT     = 200;

    logic      clk;
    logic      arst_n;
    logic      flush;
    logic      disp_valid;
    t_disp_pkt disp_pkt;
    logic      disp_ready;
    logic      ext_wr_en;
    t_wr_pkt   ext_wr_pkt;
    logic      mm_iss;
    t_iss_pkt  mm_iss_pkt;
    logic      wb_en;
    t_wr_pkt   wb_pkt;
    t_rob_id   wb_robid;

    // Reference register state and writeback scoreboard keyed by pdst
    t_data    model_regs [NUM_PREGS];
    logic     exp_valid  [NUM_PREGS];
    t_data    exp_data   [NUM_PREGS];
    t_rob_id  exp_robid  [NUM_PREGS];
    int       wb_order   [NUM_PREGS];
    int       pending;
    int       wb_seq;
    int       mm_count;
    t_iss_pkt mm_last;
    t_rob_id  rob_next;
    int       seed;
    int       err_count;
    int       check_count;
    int       test_count;

    `include "sched_tb_checks.svh"

    tb_clk_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    sched_top #(
        .NUM_RS_ENTS (NUM_RS_ENTS)
    ) UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt),
        .disp_ready (disp_ready),
        .ext_wr_en  (ext_wr_en),
        .ext_wr_pkt (ext_wr_pkt),
        .mm_iss     (mm_iss),
        .mm_iss_pkt (mm_iss_pkt),
        .wb_en      (wb_en),
        .wb_pkt     (wb_pkt),
        .wb_robid   (wb_robid)
    );

    function automatic t_data src_value(input t_optype kind, input t_preg_id preg,
                                        input t_data imm);
        case (kind)
            OP_IMM:  return imm;
            OP_REG:  return model_regs[preg];
            default: return '0;
        endcase
    endfunction

    function automatic t_data alu_model(input t_disp_pkt p);
        t_data a;
        t_data b;
        a = src_value(p.src1_optype, p.psrc1, p.imm);
        b = src_value(p.src2_optype, p.psrc2, p.imm);
        case (p.uop)
            UOP_ADD: return a + b;
            UOP_SUB: return a - b;
            UOP_AND: return a & b;
            UOP_OR:  return a | b;
            default: return a ^ b;
        endcase
    endfunction

    // Fresh robid and random immediate per op
    function automatic t_disp_pkt make_op(input t_uop uop, input t_optype k1, input t_preg_id s1,
                                          input logic r1, input t_optype k2, input t_preg_id s2,
                                          input logic r2, input t_preg_id dst);
        t_disp_pkt p;
        p.uop         = uop;
        p.src1_optype = k1;
        p.psrc1       = s1;
        p.src1_ready  = r1;
        p.src2_optype = k2;
        p.psrc2       = s2;
        p.src2_ready  = r2;
        p.pdst        = dst;
        p.robid       = rob_next;
        p.imm         = $random(seed);
        rob_next      = rob_next + 1'b1;
        return p;
    endfunction

    task automatic send_op(input t_disp_pkt p);
        disp_pkt   = p;
        disp_valid = 1'b1;
        wait_ready();
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    task automatic send_alu(input t_disp_pkt p);
        t_data res;
        res                = alu_model(p);
        model_regs[p.pdst] = res;
        exp_data[p.pdst]   = res;
        exp_robid[p.pdst]  = p.robid;
        exp_valid[p.pdst]  = 1'b1;
        pending++;
        send_op(p);
    endtask

    task automatic ext_write(input t_preg_id preg, input t_data data);
        ext_wr_pkt.preg  = preg;
        ext_wr_pkt.data  = data;
        ext_wr_en        = 1'b1;
        model_regs[preg] = data;
        @(posedge clk);
        #1;
        ext_wr_en = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            compare_bit("wb_en", wb_en, 1'b0);
            compare_bit("mm_iss", mm_iss, 1'b0);
        end
    endtask

    task automatic check_writeback();
        t_wr_pkt exp;
        if (!exp_valid[wb_pkt.preg]) begin
            err_count++;
            $display("ERROR %0t: unexpected writeback to preg %0d", $time, wb_pkt.preg);
        end else begin
            exp.preg = wb_pkt.preg;
            exp.data = exp_data[wb_pkt.preg];
            compare_wr("wb_pkt", wb_pkt, exp);
            compare_rob("wb_robid", wb_robid, exp_robid[wb_pkt.preg]);
            exp_valid[wb_pkt.preg] = 1'b0;
            wb_order[wb_pkt.preg]  = wb_seq;
            wb_seq++;
            pending--;
        end
    endtask

    // Sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n && wb_en) begin
            check_writeback();
        end
        if (arst_n && mm_iss) begin
            mm_last = mm_iss_pkt;
            mm_count++;
        end
    end

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic run_after_reset();
        int errs;
        errs = err_count;
        compare_bit("disp_ready", disp_ready, 1'b1);
        idle_cycles(10);
        end_test("after reset", errs);
    endtask

    task automatic run_independent();
        int errs;
        errs = err_count;
        for (int r = 1; r <= 3; r++) begin
            ext_write(t_preg_id'(r), $random(seed));
        end
        send_alu(make_op(UOP_ADD, OP_REG, 1, 1, OP_IMM, 0, 0, 4));
        send_alu(make_op(UOP_SUB, OP_REG, 2, 1, OP_REG, 3, 1, 5));
        send_alu(make_op(UOP_XOR, OP_IMM, 0, 0, OP_ZERO, 0, 0, 6));
        send_alu(make_op(UOP_OR, OP_REG, 3, 1, OP_IMM, 0, 0, 7));
        drain_writebacks();
        end_test("independent alu ops", errs);
    endtask

    task automatic run_chain();
        int errs;
        errs = err_count;
        send_alu(make_op(UOP_ADD, OP_IMM, 0, 0, OP_ZERO, 0, 0, 8));
        for (int i = 9; i <= 12; i++) begin
            send_alu(make_op(t_uop'(i % 5), OP_REG, t_preg_id'(i - 1), 0, OP_IMM, 0, 0,
                             t_preg_id'(i)));
        end
        drain_writebacks();
        for (int i = 9; i <= 12; i++) begin
            if (wb_order[i] <= wb_order[i - 1]) begin
                err_count++;
                $display("ERROR %0t: preg %0d written back before its producer", $time, i);
            end
        end
        end_test("dependency chain", errs);
    endtask

    task automatic run_load();
        int        errs;
        int        mm_base;
        t_disp_pkt ld;
        t_iss_pkt  exp_iss;
        t_data     ld_data;
        errs    = err_count;
        mm_base = mm_count;
        ld      = make_op(UOP_LOAD, OP_REG, 1, 1, OP_IMM, 0, 0, 13);
        exp_iss.disp     = ld;
        exp_iss.src1_val = src_value(ld.src1_optype, ld.psrc1, ld.imm);
        exp_iss.src2_val = src_value(ld.src2_optype, ld.psrc2, ld.imm);
        send_op(ld);
        ld_data        = $random(seed);
        model_regs[13] = ld_data;
        send_alu(make_op(UOP_SUB, OP_REG, 13, 0, OP_REG, 2, 1, 14));
        wait_mm(mm_base + 1);
        compare_iss("mm_iss_pkt", mm_last, exp_iss);
        ext_write(13, ld_data);
        drain_writebacks();
        end_test("memory steering and load wakeup", errs);
    endtask

    task automatic run_backpressure();
        int    errs;
        t_data v;
        errs           = err_count;
        v              = $random(seed);
        model_regs[15] = v;
        for (int i = 0; i < NUM_RS_ENTS; i++) begin
            send_alu(make_op(t_uop'(i % 5), OP_REG, 15, 0, OP_IMM, 0, 0, t_preg_id'(16 + i)));
        end
        compare_bit("disp_ready", disp_ready, 1'b0);
        ext_write(15, v);
        drain_writebacks();
        wait_ready();
        compare_bit("disp_ready", disp_ready, 1'b1);
        end_test("back-pressure", errs);
    endtask

    task automatic run_flush();
        int errs;
        int mm_base;
        errs    = err_count;
        mm_base = mm_count;
        send_op(make_op(UOP_ADD, OP_REG, 24, 0, OP_IMM, 0, 0, 25));
        send_op(make_op(UOP_XOR, OP_REG, 24, 0, OP_REG, 1, 1, 26));
        send_op(make_op(UOP_LOAD, OP_REG, 24, 0, OP_ZERO, 0, 0, 27));
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        ext_write(24, $random(seed));
        idle_cycles(10);
        if (mm_count != mm_base) begin
            err_count++;
            $display("ERROR %0t: flushed load still reached the memory port", $time);
        end
        compare_bit("disp_ready", disp_ready, 1'b1);
        send_alu(make_op(UOP_AND, OP_REG, 24, 1, OP_IMM, 0, 0, 28));
        drain_writebacks();
        end_test("flush", errs);
    endtask

    initial begin
        flush       = 1'b0;
        disp_valid  = 1'b0;
        disp_pkt    = '0;
        ext_wr_en   = 1'b0;
        ext_wr_pkt  = '0;
        seed        = 89;
        rob_next    = '0;
        pending     = 0;
        wb_seq      = 1;
        mm_count    = 0;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        for (int r = 0; r < NUM_PREGS; r++) begin
            model_regs[r] = '0;
            exp_valid[r]  = 1'b0;
            wb_order[r]   = 0;
        end
        wait_reset();
        run_after_reset();
        run_independent();
        run_chain();
        run_load();
        run_backpressure();
        run_flush();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sched_top.f */
+incdir+bench
src/sched_pkg.sv
src/rs_entry.sv
src/rs.sv
src/prf.sv
src/alu_unit.sv
src/sched_top.sv
bench/tb_clk_gen.sv
bench/sched_tb.sv
